// ==== hw/cnn_geom_pkg.sv ====
package cnn_geom_pkg;

    // ========================================================================
    // image and kernel geometry
    // ========================================================================
    localparam int IMG_W  = 8;
    localparam int IMG_H  = 8;
    localparam int KER    = 3;
    localparam int OUT_W  = IMG_W - KER + 1;
    localparam int OUT_H  = IMG_H - KER + 1;
    localparam int NUM_CO = 2;

    // datapath widths, weights and biases are signed
    localparam int PIX_BW   = 8;
    localparam int W_BW     = 8;
    localparam int B_BW     = 16;
    // nine 8x8 products plus bias stay well below 2^19
    localparam int ACC_BW   = 20;
    localparam int COORD_BW = 3;

    // ========================================================================
    // buffering and frame store
    // ========================================================================
    localparam int PIX_FIFO_DEPTH = 4;
    localparam int RES_FIFO_DEPTH = 4;
    localparam int CRED_BW        = 3;
    localparam int IMG_AW         = 6;

endpackage

// ==== hw/cnn_types_pkg.sv ====
package cnn_types_pkg;

    import cnn_geom_pkg::*;

    // one streamed pixel
    // last marks the final pixel of a frame
    typedef struct packed {
        logic              last;
        logic [PIX_BW-1:0] value;
    } pixel_t;

    // w[co][ky][kx]
    // ky runs top row to bottom row, kx left column to right column
    typedef struct packed {
        logic [NUM_CO-1:0][KER-1:0][KER-1:0][W_BW-1:0] w;
    } kernel_t;

    // one signed bias per output channel
    typedef struct packed {
        logic [NUM_CO-1:0][B_BW-1:0] b;
    } bias_t;

    // post-ReLU channel values, output coordinates and frame end
    typedef struct packed {
        logic [NUM_CO-1:0][ACC_BW-1:0] ch;
        logic [COORD_BW-1:0]           x;
        logic [COORD_BW-1:0]           y;
        logic                          last;
    } result_t;

    // 9 + 144 + 32 + 47 bits
    // the FIFO and top rely on these packed widths

endpackage

// ==== hw/fmap_feeder.sv ====
`timescale 1ns/1ps

module fmap_feeder (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            i_img_we,
    input  logic [cnn_geom_pkg::IMG_AW-1:0] i_img_addr,
    input  logic [cnn_geom_pkg::PIX_BW-1:0] i_img_data,
    input  logic                            i_start,
    input  logic                            i_credit,
    output logic                            o_push,
    output cnn_types_pkg::pixel_t           o_pixel,
    output logic                            o_busy
);

    import cnn_geom_pkg::*;

    localparam int NUM_PIX = IMG_W * IMG_H;

    logic [PIX_BW-1:0]  frame_mem [NUM_PIX];
    logic [IMG_AW-1:0]  rd_addr;
    logic [CRED_BW-1:0] credit_cnt;
    logic               busy;
    logic               last_pix;

    // frame store write port
    always_ff @(posedge clk) begin
        if (i_img_we) begin
            frame_mem[i_img_addr] <= i_img_data;
        end
    end

    assign last_pix      = (rd_addr == IMG_AW'(NUM_PIX - 1));
    assign o_push        = busy && (credit_cnt != '0);
    assign o_pixel.value = frame_mem[rd_addr];
    assign o_pixel.last  = last_pix;
    assign o_busy        = busy;

    // ========================================================================
    // raster read sequencing
    // ========================================================================
    // start is only accepted while idle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy    <= 1'b0;
            rd_addr <= '0;
        end else if (!busy) begin
            if (i_start) begin
                busy    <= 1'b1;
                rd_addr <= '0;
            end
        end else if (o_push) begin
            rd_addr <= rd_addr + 1'b1;
            if (last_pix) begin
                busy <= 1'b0;
            end
        end
    end

    // credits for the pixel FIFO
    // push spends one, return pulse gives one back
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            credit_cnt <= CRED_BW'(PIX_FIFO_DEPTH);
        end else begin
            credit_cnt <= credit_cnt - CRED_BW'(o_push) + CRED_BW'(i_credit);
        end
    end

endmodule

// ==== hw/credit_fifo.sv ====
`timescale 1ns/1ps

module credit_fifo #(
    parameter type payload_t = cnn_types_pkg::pixel_t,
    parameter int  DEPTH     = cnn_geom_pkg::PIX_FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     i_push,
    input  payload_t i_data,
    input  logic     i_pop,
    output payload_t o_data,
    output logic     o_not_empty,
    output logic     o_credit
);

    localparam int PTR_BW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BW = $clog2(DEPTH + 1);

    payload_t          mem [DEPTH];
    logic [PTR_BW-1:0] wr_ptr;
    logic [PTR_BW-1:0] rd_ptr;
    logic [CNT_BW-1:0] count;
    logic              pop_ok;

    // wrap at DEPTH so non power of two depths also work
    function automatic logic [PTR_BW-1:0] next_ptr(input logic [PTR_BW-1:0] ptr);
        return (ptr == PTR_BW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // show-ahead read side
    assign o_not_empty = (count != '0);
    assign o_data      = mem[rd_ptr];
    assign pop_ok      = i_pop && o_not_empty;

    // a freed slot goes straight back to the sender
    assign o_credit = pop_ok;

    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    // ========================================================================
    // pointers and occupancy
    // ========================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_ok) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({i_push, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hw/conv_core.sv ====
`timescale 1ns/1ps

module conv_core (
    input  logic                    clk,
    input  logic                    reset_n,
    input  cnn_types_pkg::pixel_t   i_pix,
    input  logic                    i_pix_avail,
    input  cnn_types_pkg::kernel_t  i_weight,
    input  cnn_types_pkg::bias_t    i_bias,
    input  logic                    i_credit,
    output logic                    o_pix_pop,
    output logic                    o_push,
    output cnn_types_pkg::result_t  o_result
);

    import cnn_geom_pkg::*;
    import cnn_types_pkg::*;

    localparam int COL_BW = $clog2(IMG_W);
    localparam int ROW_BW = $clog2(IMG_H);
    localparam int LB_N   = KER - 1;

    // line_buf[0] holds row-2, line_buf[1] holds row-1
    logic [PIX_BW-1:0]        line_buf [LB_N][IMG_W];
    // left two window columns, the third is the incoming column
    logic [PIX_BW-1:0]        win [KER][LB_N];
    logic [PIX_BW-1:0]        col_in [KER];
    logic [PIX_BW-1:0]        cur [KER][KER];
    logic [COL_BW-1:0]        col;
    logic [ROW_BW-1:0]        row;
    logic [CRED_BW-1:0]       credit_cnt;
    logic [CRED_BW-1:0]       credit_free;
    logic                     pop;
    logic                     win_done;
    logic signed [ACC_BW-1:0] sum [NUM_CO];
    result_t                  res_d;

    // ========================================================================
    // flow control
    // ========================================================================
    // a push already in flight holds one credit
    assign credit_free = credit_cnt - CRED_BW'(o_push);
    assign pop         = i_pix_avail && (credit_free != '0);
    assign o_pix_pop   = pop;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            credit_cnt <= CRED_BW'(RES_FIFO_DEPTH);
        end else begin
            credit_cnt <= credit_cnt - CRED_BW'(o_push) + CRED_BW'(i_credit);
        end
    end

    // input position of the pixel at the FIFO head
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            col <= '0;
            row <= '0;
        end else if (pop) begin
            if (i_pix.last) begin
                col <= '0;
                row <= '0;
            end else if (col == COL_BW'(IMG_W - 1)) begin
                col <= '0;
                row <= (row == ROW_BW'(IMG_H - 1)) ? '0 : row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // ========================================================================
    // line buffers and window
    // ========================================================================
    always_comb begin
        for (int k = 0; k < LB_N; k++) begin
            col_in[k] = line_buf[k][col];
        end
        col_in[KER-1] = i_pix.value;
    end

    always_comb begin
        for (int r = 0; r < KER; r++) begin
            for (int c = 0; c < LB_N; c++) begin
                cur[r][c] = win[r][c];
            end
            cur[r][KER-1] = col_in[r];
        end
    end

    // shift the column up the line buffers and the window left
    always_ff @(posedge clk) begin
        if (pop) begin
            for (int k = 0; k < LB_N; k++) begin
                line_buf[k][col] <= col_in[k+1];
            end
            for (int r = 0; r < KER; r++) begin
                for (int c = 0; c < LB_N; c++) begin
                    win[r][c] <= cur[r][c+1];
                end
            end
        end
    end

    assign win_done = (col >= COL_BW'(LB_N)) && (row >= ROW_BW'(LB_N));

    // ========================================================================
    // multiply-accumulate, bias and ReLU
    // ========================================================================
    // pixels are unsigned, zero extend before the signed multiply
    always_comb begin
        for (int co = 0; co < NUM_CO; co++) begin
            sum[co] = $signed(i_bias.b[co]);
            for (int ky = 0; ky < KER; ky++) begin
                for (int kx = 0; kx < KER; kx++) begin
                    sum[co] = sum[co] + $signed({1'b0, cur[ky][kx]}) *
                              $signed(i_weight.w[co][ky][kx]);
                end
            end
        end
    end

    always_comb begin
        for (int co = 0; co < NUM_CO; co++) begin
            res_d.ch[co] = sum[co][ACC_BW-1] ? '0 : sum[co];
        end
        res_d.x    = COORD_BW'(col - COL_BW'(LB_N));
        res_d.y    = COORD_BW'(row - ROW_BW'(LB_N));
        // bottom right input pixel closes output OUT_W-1, OUT_H-1
        res_d.last = (col == COL_BW'(IMG_W - 1)) && (row == ROW_BW'(IMG_H - 1));
    end

    // result leaves one cycle after its completing pixel
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_push <= 1'b0;
        end else begin
            o_push <= pop && win_done;
        end
    end

    always_ff @(posedge clk) begin
        if (pop && win_done) begin
            o_result <= res_d;
        end
    end

endmodule

// ==== hw/cnn_top.sv ====
`timescale 1ns/1ps

module cnn_top (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            i_img_we,
    input  logic [cnn_geom_pkg::IMG_AW-1:0] i_img_addr,
    input  logic [cnn_geom_pkg::PIX_BW-1:0] i_img_data,
    input  logic                            i_start,
    input  cnn_types_pkg::kernel_t          i_weight,
    input  cnn_types_pkg::bias_t            i_bias,
    input  logic                            i_out_ready,
    output logic                            o_busy,
    output logic                            o_out_valid,
    output cnn_types_pkg::result_t          o_out
);

    import cnn_geom_pkg::*;
    import cnn_types_pkg::*;

    // feeder to pixel FIFO
    logic    pix_push;
    pixel_t  pix_in;
    logic    pix_credit;

    // pixel FIFO to core
    pixel_t  pix_head;
    logic    pix_avail;
    logic    pix_pop;

    // core to result FIFO
    logic    res_push;
    result_t res_in;
    logic    res_credit;

    // ========================================================================
    // producer, pixel FIFO, core, result FIFO
    // ========================================================================
    fmap_feeder u_feeder (
        .clk       (clk),
        .reset_n   (reset_n),
        .i_img_we  (i_img_we),
        .i_img_addr(i_img_addr),
        .i_img_data(i_img_data),
        .i_start   (i_start),
        .i_credit  (pix_credit),
        .o_push    (pix_push),
        .o_pixel   (pix_in),
        .o_busy    (o_busy)
    );

    credit_fifo #(
        .payload_t(pixel_t),
        .DEPTH    (PIX_FIFO_DEPTH)
    ) u_pix_fifo (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_push     (pix_push),
        .i_data     (pix_in),
        .i_pop      (pix_pop),
        .o_data     (pix_head),
        .o_not_empty(pix_avail),
        .o_credit   (pix_credit)
    );

    conv_core u_core (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_pix      (pix_head),
        .i_pix_avail(pix_avail),
        .i_weight   (i_weight),
        .i_bias     (i_bias),
        .i_credit   (res_credit),
        .o_pix_pop  (pix_pop),
        .o_push     (res_push),
        .o_result   (res_in)
    );

    // popped by the environment whenever ready and not empty
    credit_fifo #(
        .payload_t(result_t),
        .DEPTH    (RES_FIFO_DEPTH)
    ) u_res_fifo (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_push     (res_push),
        .i_data     (res_in),
        .i_pop      (i_out_ready),
        .o_data     (o_out),
        .o_not_empty(o_out_valid),
        .o_credit   (res_credit)
    );

endmodule

// ==== sim/cnn_top_assert.sv ====
`timescale 1ns/1ps

module cnn_top_assert (
    input logic clk,
    input logic reset_n,
    input logic i_pix_push,
    input logic i_pix_credit,
    input logic i_pix_pop,
    input logic i_res_push,
    input logic i_res_credit
);

    import cnn_geom_pkg::*;

    localparam int CNT_W = CRED_BW + 1;
    localparam logic [CNT_W-1:0] PIX_MAX = CNT_W'(PIX_FIFO_DEPTH);
    localparam logic [CNT_W-1:0] RES_MAX = CNT_W'(RES_FIFO_DEPTH);

    // shadow credit counters, one per link
    // depth minus credits is the FIFO occupancy
    logic [CNT_W-1:0] pix_cred;
    logic [CNT_W-1:0] res_cred;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pix_cred <= PIX_MAX;
            res_cred <= RES_MAX;
        end else begin
            pix_cred <= pix_cred - CNT_W'(i_pix_push) + CNT_W'(i_pix_credit);
            res_cred <= res_cred - CNT_W'(i_res_push) + CNT_W'(i_res_credit);
        end
    end

    // ========================================================================
    // credit link properties
    // ========================================================================
    pix_cred_max: assert property (@(posedge clk) disable iff (!reset_n)
        pix_cred <= PIX_MAX) else $error("pixel link credit count above FIFO depth");
    res_cred_max: assert property (@(posedge clk) disable iff (!reset_n)
        res_cred <= RES_MAX) else $error("result link credit count above FIFO depth");
    pix_push_cred: assert property (@(posedge clk) disable iff (!reset_n)
        i_pix_push |-> (pix_cred != '0)) else $error("pixel push with no credit left");
    res_push_cred: assert property (@(posedge clk) disable iff (!reset_n)
        i_res_push |-> (res_cred != '0)) else $error("result push with no credit left");
    pix_pop_empty: assert property (@(posedge clk) disable iff (!reset_n)
        i_pix_pop |-> (pix_cred != PIX_MAX)) else $error("pop from empty pixel FIFO");
    res_pop_empty: assert property (@(posedge clk) disable iff (!reset_n)
        i_res_credit |-> (res_cred != RES_MAX)) else $error("pop from empty result FIFO");

endmodule

bind cnn_top cnn_top_assert u_assert (
    .clk         (clk),
    .reset_n     (reset_n),
    .i_pix_push  (pix_push),
    .i_pix_credit(pix_credit),
    .i_pix_pop   (pix_pop),
    .i_res_push  (res_push),
    .i_res_credit(res_credit)
);

// ==== sim/tb_cnn_top.sv ====
`timescale 1ns/1ps

module tb_cnn_top;

    import cnn_geom_pkg::*;
    import cnn_types_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int NUM_PIX      = IMG_W * IMG_H;
    localparam int OUT_N        = OUT_W * OUT_H;
    localparam int FRAME_CYCLES = NUM_PIX * 8;
    localparam int DRAIN_CYCLES = 16;
    localparam int NUM_TESTS    = 5;
    localparam int WATCHDOG_NS  = NUM_TESTS * NUM_PIX * 8 * CLK_PERIOD + 40000;
    localparam int W_RAND       = 0;
    localparam int W_NEG        = 1;
    localparam int W_IDENT      = 2;

    typedef struct {
        string name;
        int    wmode;
        int    bias;
        int    ready_pct;
        bit    busy_start;
    } test_row_t;

    logic              clk = 1'b0;
    logic              reset_n;
    logic              i_img_we;
    logic [IMG_AW-1:0] i_img_addr;
    logic [PIX_BW-1:0] i_img_data;
    logic              i_start;
    kernel_t           i_weight;
    bias_t             i_bias;
    logic              i_out_ready;
    logic              o_busy;
    logic              o_out_valid;
    result_t           o_out;

    // reference copies of the stimulus
    logic [PIX_BW-1:0] img [NUM_PIX];
    int                wts [NUM_CO][KER][KER];
    int                bias_val;
    logic [31:0]       lfsr_state = 32'h6412;
    test_row_t         tests [NUM_TESTS];
    int                errors = 0;
    int                checks = 0;

    cnn_top cnn_top_inst (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ========================================================================
    // random source and reference model
    // ========================================================================
    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic ready_draw(input int pct);
        if (pct >= 100) begin
            return 1'b1;
        end
        return (int'(take_bits(7)) * 100) < (pct * 128);
    endfunction

    function automatic result_t expected_out(input int idx);
        result_t e;
        int      x;
        int      y;
        int      s;
        x = idx % OUT_W;
        y = idx / OUT_W;
        for (int co = 0; co < NUM_CO; co++) begin
            s = bias_val;
            for (int ky = 0; ky < KER; ky++) begin
                for (int kx = 0; kx < KER; kx++) begin
                    s += wts[co][ky][kx] * int'(img[(y + ky) * IMG_W + x + kx]);
                end
            end
            e.ch[co] = (s < 0) ? '0 : ACC_BW'(s);
        end
        e.x    = COORD_BW'(x);
        e.y    = COORD_BW'(y);
        e.last = (idx == OUT_N - 1);
        return e;
    endfunction

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            $display("error: %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // ========================================================================
    // stimulus
    // ========================================================================
    task automatic set_kernel(input int wmode, input int bias);
        kernel_t     k;
        bias_t       b;
        logic [31:0] r;
        for (int co = 0; co < NUM_CO; co++) begin
            for (int ky = 0; ky < KER; ky++) begin
                for (int kx = 0; kx < KER; kx++) begin
                    r = take_bits(W_BW);
                    if (wmode == W_RAND) begin
                        wts[co][ky][kx] = int'($signed(r[W_BW-1:0]));
                    end else if (wmode == W_NEG) begin
                        wts[co][ky][kx] = -(int'(r[W_BW-2:0]) + 1);
                    end else begin
                        wts[co][ky][kx] = 0;
                    end
                    k.w[co][ky][kx] = W_BW'(wts[co][ky][kx]);
                end
            end
            b.b[co] = B_BW'(bias);
        end
        if (wmode == W_IDENT) begin
            // ch1 negates the centre pixel
            wts[0][1][1] = 1;
            wts[1][1][1] = -1;
            k.w[0][1][1] = W_BW'(1);
            k.w[1][1][1] = W_BW'(-1);
        end
        bias_val = bias;
        @(posedge clk);
        i_weight <= k;
        i_bias   <= b;
    endtask

    task automatic write_image();
        for (int a = 0; a < NUM_PIX; a++) begin
            img[a] = PIX_BW'(take_bits(PIX_BW));
            @(posedge clk);
            i_img_we   <= 1'b1;
            i_img_addr <= IMG_AW'(a);
            i_img_data <= img[a];
        end
        @(posedge clk);
        i_img_we <= 1'b0;
    endtask

    task automatic run_frame(input string tname, input int ready_pct, input bit poke_busy);
        result_t got [$];
        int      cycles;
        int      extra;
        bit      poked;
        cycles = 0;
        extra  = 0;
        poked  = 1'b0;
        @(posedge clk);
        i_start <= 1'b1;
        while (got.size() < OUT_N && cycles < FRAME_CYCLES) begin
            @(posedge clk);
            if (o_out_valid && i_out_ready) begin
                got.push_back(o_out);
            end
            // second start lands while the feeder is streaming
            if (poke_busy && !poked && o_busy) begin
                i_start <= 1'b1;
                poked = 1'b1;
            end else begin
                i_start <= 1'b0;
            end
            i_out_ready <= ready_draw(ready_pct);
            cycles++;
        end
        if (got.size() < OUT_N) begin
            $display("error: %s timed out with %0d of %0d outputs", tname, got.size(), OUT_N);
            errors++;
        end
        if (poke_busy && !poked) begin
            $display("error: %s never saw the feeder busy for the extra start", tname);
            errors++;
        end
        for (int i = 0; i < got.size(); i++) begin
            check($sformatf("%s out %0d", tname, i), 64'(expected_out(i)), 64'(got[i]));
        end
        // anything still coming out is surplus
        i_start     <= 1'b0;
        i_out_ready <= 1'b1;
        repeat (DRAIN_CYCLES) begin
            @(posedge clk);
            if (o_out_valid && i_out_ready) begin
                extra++;
            end
        end
        check({tname, " extra outputs"}, 64'(0), 64'(extra));
        check({tname, " busy after frame"}, 64'(0), 64'(o_busy));
    endtask

    // ========================================================================
    // test sequence and watchdog
    // ========================================================================
    initial begin
        int errs_before;
        tests[0] = '{"random_weights", W_RAND, 37, 100, 1'b0};
        tests[1] = '{"negative_relu", W_NEG, 0, 100, 1'b0};
        tests[2] = '{"identity_centre", W_IDENT, 100, 100, 1'b0};
        tests[3] = '{"backpressure", W_RAND, -250, 30, 1'b0};
        tests[4] = '{"start_while_busy", W_RAND, 12, 60, 1'b1};
        reset_n     = 1'b0;
        i_img_we    = 1'b0;
        i_img_addr  = '0;
        i_img_data  = '0;
        i_start     = 1'b0;
        i_weight    = '0;
        i_bias      = '0;
        i_out_ready = 1'b0;
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            errs_before = errors;
            set_kernel(tests[t].wmode, tests[t].bias);
            write_image();
            run_frame(tests[t].name, tests[t].ready_pct, tests[t].busy_start);
            if (tests[t].busy_start) begin
                write_image();
                run_frame({tests[t].name, " second"}, tests[t].ready_pct, 1'b0);
            end
            $display("test %-18s %s, %0d errors", tests[t].name,
                     (errors == errs_before) ? "ok" : "failed", errors - errs_before);
        end
        $display("summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== filelist.f ====
hw/cnn_geom_pkg.sv
hw/cnn_types_pkg.sv
hw/fmap_feeder.sv
hw/credit_fifo.sv
hw/conv_core.sv
hw/cnn_top.sv
sim/cnn_top_assert.sv
sim/tb_cnn_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cnn_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_cnn_top \
    --Mdir "$BUILD_DIR" \
    -o tb_cnn_top \
    -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_cnn_top" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG_FILE"; then
    exit 0
fi
echo "pass line not found in $LOG_FILE"
exit 1
